// File: design/sqrt_cfg.svh
`ifndef SQRT_CFG_SVH
`define SQRT_CFG_SVH

// Width of the input radicand
`define SQRT_RADICAND_W 32

// Width of the root, also the number of pipeline stages
`define SQRT_ROOT_W 16

// Radicand bits consumed by one root-bit step
`define SQRT_BITS_PER_STAGE 2

`endif

// File: design/sqrt_pkg.sv
`include "sqrt_cfg.svh"

package sqrt_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath vector types
    ////////////////////////////////////////////////////////////

    // Input radicand, also the unconsumed bits inside the pipeline
    typedef logic [`SQRT_RADICAND_W-1:0] radicand_t;

    // Partial or final root
    typedef logic [`SQRT_ROOT_W-1:0] root_t;

    // Partial or final remainder, bounded by twice the root
    typedef logic [`SQRT_ROOT_W:0] rem_t;

endpackage

// File: design/sqrt_stage_if.sv
`timescale 1ns/10ps

interface sqrt_stage_if;
    import sqrt_pkg::*;

    logic      valid;
    // Most significant unconsumed pair sits at the top
    radicand_t radicand;
    root_t     root;
    rem_t      rem;

    modport src (
        output valid,
        output radicand,
        output root,
        output rem
    );

    modport dst (
        input valid,
        input radicand,
        input root,
        input rem
    );

endinterface

// File: design/sqrt_capture.sv
`timescale 1ns/10ps

module sqrt_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_req,
    input  sqrt_pkg::radicand_t in_radicand,
    output logic                in_ack,
    input  logic                advance,
    sqrt_stage_if.src           launch
);
    import sqrt_pkg::*;

    logic      accept;
    logic      launch_valid;
    radicand_t launch_radicand;

    // New item only while the pipeline moves
    assign accept = in_req && !in_ack && advance;

    ////////////////////////////////////////////////////////////
    // Input four-phase handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Launch register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            launch_valid <= 1'b0;
        end else if (advance) begin
            launch_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            launch_radicand <= in_radicand;
        end
    end

    assign launch.valid    = launch_valid;
    assign launch.radicand = launch_radicand;
    // Root and remainder start from zero
    assign launch.root     = '0;
    assign launch.rem      = '0;

    // Request still up on the cycle the ack is seen
    a_ack_after_req : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> in_req);

endmodule

// File: design/sqrt_stage.sv
`timescale 1ns/10ps
`include "sqrt_cfg.svh"

module sqrt_stage (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    sqrt_stage_if.dst up,
    sqrt_stage_if.src down
);
    import sqrt_pkg::*;

    // Remainder with the next radicand pair appended
    logic [`SQRT_ROOT_W+`SQRT_BITS_PER_STAGE:0]   shifted;
    // One extra bit on top catches the borrow
    logic [`SQRT_ROOT_W+`SQRT_BITS_PER_STAGE+1:0] diff;
    logic                                         borrow;
    radicand_t                                    next_radicand;
    root_t                                        next_root;
    rem_t                                         next_rem;

    ////////////////////////////////////////////////////////////
    // Restoring root-bit step
    ////////////////////////////////////////////////////////////

    always_comb begin
        shifted = {up.rem, up.radicand[`SQRT_RADICAND_W-1 -: `SQRT_BITS_PER_STAGE]};
        // Trial value is the root shifted left with a trailing one
        diff    = {1'b0, shifted} - {2'b00, up.root, 2'b01};
        borrow  = diff[`SQRT_ROOT_W+`SQRT_BITS_PER_STAGE+1];

        // Borrow means the trial was too big, so restore
        next_rem      = borrow ? shifted[`SQRT_ROOT_W:0] : diff[`SQRT_ROOT_W:0];
        next_root     = {up.root[`SQRT_ROOT_W-2:0], !borrow};
        next_radicand = up.radicand << `SQRT_BITS_PER_STAGE;
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////

    logic      down_valid;
    radicand_t down_radicand;
    root_t     down_root;
    rem_t      down_rem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            down_valid <= 1'b0;
        end else if (advance) begin
            down_valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && up.valid) begin
            down_radicand <= next_radicand;
            down_root     <= next_root;
            down_rem      <= next_rem;
        end
    end

    assign down.valid    = down_valid;
    assign down.radicand = down_radicand;
    assign down.root     = down_root;
    assign down.rem      = down_rem;

    // Holds for every partial result down the array
    a_rem_bound : assert property (@(posedge clk) disable iff (!rst_n)
        down.valid |-> ({1'b0, down.rem} <= {1'b0, down.root, 1'b0}));

endmodule

// File: design/sqrt_result.sv
`timescale 1ns/10ps

module sqrt_result (
    input  logic            clk,
    input  logic            rst_n,
    sqrt_stage_if.dst       last,
    output logic            advance,
    output logic            out_req,
    input  logic            out_ack,
    output sqrt_pkg::root_t out_root,
    output sqrt_pkg::rem_t  out_rem
);

    logic slot_busy;
    logic load;

    ////////////////////////////////////////////////////////////
    // Slot occupancy and pipeline advance
    ////////////////////////////////////////////////////////////

    // Slot stays taken until the host has dropped out_ack again
    assign slot_busy = out_req || out_ack;
    assign load      = last.valid && !slot_busy;

    // Stall everything while the last item has nowhere to go
    assign advance = !(last.valid && slot_busy);

    ////////////////////////////////////////////////////////////
    // Output four-phase handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req <= 1'b0;
        end else if (load) begin
            out_req <= 1'b1;
        end else if (out_ack) begin
            out_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_root <= last.root;
            out_rem  <= last.rem;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Request and data held until the host answers
    a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_root) && $stable(out_rem));

endmodule

// File: design/sqrt_array_top.sv
`timescale 1ns/10ps
`include "sqrt_cfg.svh"

module sqrt_array_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_req,
    input  sqrt_pkg::radicand_t in_radicand,
    output logic                in_ack,
    output logic                out_req,
    input  logic                out_ack,
    output sqrt_pkg::root_t     out_root,
    output sqrt_pkg::rem_t      out_rem
);

    logic advance;

    // One slot per stage boundary, launch at 0 and result at the end
    sqrt_stage_if slot [0:`SQRT_ROOT_W] ();

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    sqrt_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_radicand (in_radicand),
        .in_ack      (in_ack),
        .advance     (advance),
        .launch      (slot[0])
    );

    ////////////////////////////////////////////////////////////
    // Root-bit stages, most significant bit first
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `SQRT_ROOT_W; k++) begin : g_stage
        sqrt_stage u_stage (
            .clk     (clk),
            .rst_n   (rst_n),
            .advance (advance),
            .up      (slot[k]),
            .down    (slot[k+1])
        );
    end

    // Output side
    sqrt_result u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .last     (slot[`SQRT_ROOT_W]),
        .advance  (advance),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_root (out_root),
        .out_rem  (out_rem)
    );

endmodule

// File: verif/tb_sqrt_array.sv
`timescale 1ns/10ps
`include "sqrt_cfg.svh"

module tb_sqrt_array;
    import sqrt_pkg::*;

    localparam int N_CORNER       = 10;
    localparam int N_RANDOM       = 300;
    localparam int N_BURST        = 40;
    localparam int TIMEOUT_CYCLES = (N_CORNER + N_RANDOM + N_BURST) * 60 + 200;

    logic      clk;
    logic      rst_n;
    logic      in_req;
    radicand_t in_radicand;
    logic      in_ack;
    logic      out_req;
    logic      out_ack;
    root_t     out_root;
    rem_t      out_rem;

    radicand_t model_queue[$];
    int        error_count    = 0;
    int        sent_count     = 0;
    int        result_count   = 0;
    int        ack_delay_max  = 0;
    int        ack_rises      = 0;
    int        req_rises      = 0;
    int        in_flight_peak = 0;
    logic      in_ack_q       = 1'b0;
    logic      out_req_q      = 1'b0;
    root_t     last_root;
    rem_t      last_rem;

    sqrt_array_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_radicand (in_radicand),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_root    (out_root),
        .out_rem     (out_rem)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Largest root whose square still fits, by bisection
    function automatic root_t model_root(input radicand_t value);
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned mid;
        lo = 0;
        hi = (64'd1 << `SQRT_ROOT_W) - 1;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= 64'(value)) begin
                lo = mid;
            end else begin
                hi = mid - 1;
            end
        end
        return root_t'(lo);
    endfunction

    function automatic rem_t model_rem(input radicand_t value);
        longint unsigned root;
        root = 64'(model_root(value));
        return rem_t'(64'(value) - root * root);
    endfunction

    ////////////////////////////////////////////////////////////
    // Host, sink and monitor
    ////////////////////////////////////////////////////////////

    task automatic send_radicand(input radicand_t value);
        @(posedge clk);
        in_req      <= 1'b1;
        in_radicand <= value;
        do @(negedge clk); while (in_ack !== 1'b1);
        model_queue.push_back(value);
        sent_count++;
        @(posedge clk);
        in_req <= 1'b0;
        do @(negedge clk); while (in_ack !== 1'b0);
    endtask

    task automatic check_result();
        radicand_t       value;
        longint unsigned r;
        longint unsigned v;
        assert (model_queue.size() != 0) else begin
            error_count++;
            $display("Result at %0t arrived with no radicand pending", $time);
        end
        if (model_queue.size() != 0) begin
            value = model_queue.pop_front();
            r = 64'(out_root);
            v = 64'(value);
            assert (r * r <= v && v < (r + 1) * (r + 1)) else begin
                error_count++;
                $display("[FAIL] t=%0t out_root for %0d expected %0d got %0d (bound)",
                         $time, value, model_root(value), out_root);
            end
            assert (out_root == model_root(value)) else begin
                error_count++;
                $display("[FAIL] t=%0t out_root for %0d expected %0d got %0d",
                         $time, value, model_root(value), out_root);
            end
            assert (out_rem == model_rem(value)) else begin
                error_count++;
                $display("[FAIL] t=%0t out_rem for %0d expected %0d got %0d",
                         $time, value, model_rem(value), out_rem);
            end
        end
        last_root = out_root;
        last_rem  = out_rem;
        result_count++;
    endtask

    initial begin : sink
        int delay;
        forever begin
            @(negedge clk);
            if (out_req === 1'b1) begin
                check_result();
                delay = (ack_delay_max == 0) ? 0 : int'($urandom_range(ack_delay_max, 0));
                repeat (delay) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                do @(negedge clk); while (out_req === 1'b1);
                @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    // Items in flight between in_ack rise and out_req rise
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_ack && !in_ack_q) ack_rises++;
            if (out_req && !out_req_q) req_rises++;
            if (ack_rises - req_rises > in_flight_peak) in_flight_peak = ack_rises - req_rises;
        end
        in_ack_q  = in_ack;
        out_req_q = out_req;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d results seen",
                 cycles, result_count, sent_count);
        $display("TB FAILED");
        $finish;
    end

    task automatic wait_drained();
        while (result_count != sent_count) @(negedge clk);
        while (out_ack !== 1'b0 || out_req !== 1'b0) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic run_reset_test();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        assert (in_ack == 1'b0) else begin
            error_count++;
            $display("[FAIL] t=%0t in_ack expected 0 got %b", $time, in_ack);
        end
        assert (out_req == 1'b0) else begin
            error_count++;
            $display("[FAIL] t=%0t out_req expected 0 got %b", $time, out_req);
        end
        $display("test reset   items 0 errors %0d", error_count - errors_before);
    endtask

    task automatic run_corner_test();
        radicand_t corner_value [N_CORNER];
        root_t     corner_root [N_CORNER];
        rem_t      corner_rem [N_CORNER];
        int        errors_before;
        errors_before = error_count;
        corner_value = '{32'h0, 32'h1, 32'hffff_ffff, 32'd4, 32'd9, 32'd144, 32'h0001_0000,
                         32'h4000_0000, 32'hfffe_0001, 32'd152399025};
        corner_root  = '{16'd0, 16'd1, 16'd65535, 16'd2, 16'd3, 16'd12, 16'd256,
                         16'd32768, 16'd65535, 16'd12345};
        corner_rem   = '{17'd0, 17'd0, 17'd131070, 17'd0, 17'd0, 17'd0, 17'd0,
                         17'd0, 17'd0, 17'd0};
        ack_delay_max = 0;
        for (int i = 0; i < N_CORNER; i++) begin
            send_radicand(corner_value[i]);
            wait_drained();
            assert (last_root == corner_root[i]) else begin
                error_count++;
                $display("[FAIL] t=%0t out_root expected %0d got %0d",
                         $time, corner_root[i], last_root);
            end
            assert (last_rem == corner_rem[i]) else begin
                error_count++;
                $display("[FAIL] t=%0t out_rem expected %0d got %0d",
                         $time, corner_rem[i], last_rem);
            end
        end
        $display("test corner  items %0d errors %0d", N_CORNER, error_count - errors_before);
    endtask

    // Random radicands with a slow, random sink
    task automatic run_random_test();
        int errors_before;
        errors_before = error_count;
        ack_delay_max = 20;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_radicand(radicand_t'($urandom()));
        end
        wait_drained();
        assert (model_queue.size() == 0) else begin
            error_count++;
            $display("Random run ended with %0d radicands still waiting for a result",
                     model_queue.size());
        end
        $display("test random  items %0d errors %0d", N_RANDOM, error_count - errors_before);
    endtask

    task automatic run_burst_test();
        int errors_before;
        errors_before  = error_count;
        ack_delay_max  = 0;
        in_flight_peak = 0;
        for (int i = 0; i < N_BURST; i++) begin
            send_radicand(radicand_t'($urandom()));
        end
        wait_drained();
        assert (in_flight_peak > 1) else begin
            error_count++;
            $display("Burst run never had more than one item in flight, peak %0d",
                     in_flight_peak);
        end
        $display("test burst   items %0d errors %0d", N_BURST, error_count - errors_before);
    endtask

    initial begin
        void'($urandom(32'hb862_f6a8));
        rst_n       = 1'b0;
        in_req      = 1'b0;
        in_radicand = '0;
        out_ack     = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        run_reset_test();
        run_corner_test();
        run_random_test();
        run_burst_test();
        // No stray result may follow the last one
        repeat (40) @(negedge clk);
        assert (req_rises == ack_rises) else begin
            error_count++;
            $display("Saw %0d results for %0d accepted radicands", req_rises, ack_rises);
        end
        $display("Summary: 4 tests, %0d radicands, %0d results, %0d errors",
                 sent_count, result_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/sqrt_pkg.sv
design/sqrt_stage_if.sv
design/sqrt_capture.sv
design/sqrt_stage.sv
design/sqrt_result.sv
design/sqrt_array_top.sv
verif/tb_sqrt_array.sv

// File: Makefile
TOP := tb_sqrt_array
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/10ps -j 0 -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
